//--- Makefile
# Verilator build and run of the I3C target configuration testbench

VERILATOR ?= verilator
TOP       ?= tb_i3c_target_cfg
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard include/*.svh)
PASS_MSG := All checks passed

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

check:
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "Simulation passed" || \
	  (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+include
hdl/i3c_cfg_pkg.sv
hdl/i3c_csr_regs.sv
hdl/i3c_target_config.sv
hdl/i3c_ccc_responder.sv
hdl/i3c_target_cfg_top.sv
test/tb_i3c_target_cfg.sv

//--- hdl/i3c_ccc_responder.sv
// Commands arrive already decoded; broadcast GET and SET commands are answered like direct ones
`timescale 1ns/1ns
`include "i3c_settings.svh"

module i3c_ccc_responder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  i3c_cfg_pkg::ccc_cmd_t    cmd_i,
  input  i3c_cfg_pkg::target_cfg_t cfg_i,
  output logic                     ack_o,
  output i3c_cfg_pkg::ccc_resp_t   resp_o,
  output i3c_cfg_pkg::len_update_t upd_o
);
  import i3c_cfg_pkg::*;

  logic        ack_q;
  logic        take;
  logic        own_valid;
  logic [6:0]  own_addr;
  logic        own_hit;
  logic        bcast;
  ccc_resp_t   resp_d;
  ccc_resp_t   resp_q;
  len_update_t upd_d;
  len_update_t upd_q;

  assign take = req_i & ~ack_q;

  // Dynamic address wins, static is the fallback
  assign own_valid = cfg_i.dyn_addr_valid | cfg_i.sta_addr_valid;
  assign own_addr  = cfg_i.dyn_addr_valid ? cfg_i.dyn_addr : cfg_i.sta_addr;
  assign own_hit   = own_valid & (cmd_i.addr == own_addr);
  assign bcast     = cmd_i.addr == `I3C_BCAST_ADDR;

  always_comb begin
    resp_d = '0;
    upd_d  = '0;
    case (cmd_i.kind)
      CMD_ENTDAA: begin
        // Only targets still waiting for an address take part
        resp_d.hit    = bcast & ~cfg_i.dyn_addr_valid;
        resp_d.data   = {cfg_i.pid, cfg_i.bcr, cfg_i.dcr};
        resp_d.nbytes = 4'd8;
      end
      CMD_GETPID: begin
        resp_d.hit    = own_hit | bcast;
        resp_d.data   = {16'h0000, cfg_i.pid};
        resp_d.nbytes = 4'd6;
      end
      CMD_GETMWL: begin
        resp_d.hit    = own_hit | bcast;
        resp_d.data   = {48'h0, cfg_i.mwl};
        resp_d.nbytes = 4'd2;
      end
      CMD_GETMRL: begin
        resp_d.hit    = own_hit | bcast;
        resp_d.data   = {48'h0, cfg_i.mrl};
        resp_d.nbytes = 4'd2;
      end
      CMD_GETSTATUS: begin
        resp_d.hit    = own_hit | bcast;
        resp_d.data   = {48'h0, cfg_i.status_fmt1};
        resp_d.nbytes = 4'd2;
      end
      CMD_SETMWL: begin
        resp_d.hit    = own_hit | bcast;
        upd_d.set_mwl = 1'b1;
        upd_d.value   = cmd_i.data;
      end
      CMD_SETMRL: begin
        resp_d.hit    = own_hit | bcast;
        upd_d.set_mrl = 1'b1;
        upd_d.value   = cmd_i.data;
      end
      CMD_PRIVATE: begin
        resp_d.hit = own_hit;
      end
      default: begin
        resp_d = '0;
      end
    endcase
    // Not for us
    if (!resp_d.hit) begin
      resp_d = '0;
      upd_d  = '0;
    end
  end

  // Reply is captured with the ack and held until the next request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      resp_q <= '0;
      upd_q  <= '0;
    end else begin
      upd_q <= '0;
      if (take) begin
        ack_q  <= 1'b1;
        resp_q <= resp_d;
        upd_q  <= upd_d;
      end else if (!req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  assign ack_o  = ack_q;
  assign resp_o = resp_q;
  assign upd_o  = upd_q;

  // Master waits for ack low before a new command
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_i) |-> !ack_q);

  // Length update is a one-cycle pulse that comes with an acknowledged hit
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (upd_q.set_mwl || upd_q.set_mrl) |->
      (($rose(ack_q) && resp_q.hit) ##1 !(upd_q.set_mwl || upd_q.set_mrl)));

endmodule

//--- hdl/i3c_cfg_pkg.sv
// Shared types for the target configuration path; timing width follows the settings header
`include "i3c_settings.svh"

package i3c_cfg_pkg;

  // One host register write
  typedef struct packed {
    logic [3:0]  addr;
    logic [31:0] data;
  } csr_wr_t;

  // All fields held by the CSR block
  typedef struct packed {
    logic                    bus_enable;
    logic [1:0]              enable_init;
    logic                    ibi_en;
    logic [2:0]              ibi_retry_num;
    logic [6:0]              static_addr;
    logic                    static_addr_valid;
    logic [6:0]              dynamic_addr;
    logic                    dynamic_addr_valid;
    logic [14:0]             pid_hi;
    logic [31:0]             pid_lo;
    logic [7:0]              bcr;
    logic [7:0]              dcr;
    logic [2:0]              tx_qsize;
    logic [2:0]              rx_qsize;
    logic                    protocol_error;
    logic [3:0]              pending_interrupt;
    logic [`I3C_TIMER_W-1:0] t_free;
    logic [`I3C_TIMER_W-1:0] t_idle;
    logic [`I3C_TIMER_W-1:0] t_aval;
  } csr_out_t;

  typedef struct packed {
    logic        phy_en;
    logic [1:0]  phy_mux_select;
    logic        i3c_active_en;
    logic        i3c_standby_en;
    logic [6:0]  sta_addr;
    logic        sta_addr_valid;
    logic [6:0]  dyn_addr;
    logic        dyn_addr_valid;
    logic [6:0]  ibi_addr;
    logic        ibi_addr_valid;
    logic [47:0] pid;
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic [15:0] status_fmt1;
    logic        ibi_en;
    logic [2:0]  ibi_retry_num;
  } target_cfg_t;

  typedef struct packed {
    logic [`I3C_TIMER_W-1:0] t_bus_free;
    logic [`I3C_TIMER_W-1:0] t_bus_idle;
    logic [`I3C_TIMER_W-1:0] t_bus_available;
  } timing_cfg_t;

  typedef enum logic [2:0] {
    CMD_ENTDAA,
    CMD_GETPID,
    CMD_GETMWL,
    CMD_GETMRL,
    CMD_GETSTATUS,
    CMD_SETMWL,
    CMD_SETMRL,
    CMD_PRIVATE
  } ccc_kind_e;

  typedef struct packed {
    ccc_kind_e   kind;
    logic [6:0]  addr;
    logic [15:0] data;
  } ccc_cmd_t;

  typedef struct packed {
    logic        hit;
    logic [63:0] data;
    logic [3:0]  nbytes;
  } ccc_resp_t;

  typedef struct packed {
    logic        set_mwl;
    logic        set_mrl;
    logic [15:0] value;
  } len_update_t;

endpackage

//--- hdl/i3c_csr_regs.sv
// Write-only host port; writes to unmapped indices are dropped and nothing is readable
`timescale 1ns/1ns
`include "i3c_settings.svh"

module i3c_csr_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  i3c_cfg_pkg::csr_wr_t  wr_i,
  output logic                  ack_o,
  output i3c_cfg_pkg::csr_out_t csr_o
);
  import i3c_cfg_pkg::*;

  // Queue sizes come up at their defaults, the rest at zero
  localparam csr_out_t CSR_RESET = '{
    tx_qsize: `I3C_RST_TX_QSIZE,
    rx_qsize: `I3C_RST_RX_QSIZE,
    default:  '0
  };

  logic     ack_q;
  logic     wr_en;
  csr_out_t csr_d;
  csr_out_t csr_q;

  // First edge that sees req with ack still low
  assign wr_en = req_i & ~ack_q;

  // Four-phase slave side
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (wr_en) begin
      ack_q <= 1'b1;
    end else if (!req_i) begin
      ack_q <= 1'b0;
    end
  end

  // Field layout per register word
  always_comb begin
    csr_d = csr_q;
    if (wr_en) begin
      case (wr_i.addr)
        `I3C_REG_CONTROL: begin
          csr_d.bus_enable    = wr_i.data[0];
          csr_d.enable_init   = wr_i.data[5:4];
          csr_d.ibi_en        = wr_i.data[8];
          csr_d.ibi_retry_num = wr_i.data[11:9];
        end
        `I3C_REG_DEV_ADDR: begin
          csr_d.static_addr        = wr_i.data[6:0];
          csr_d.static_addr_valid  = wr_i.data[15];
          csr_d.dynamic_addr       = wr_i.data[22:16];
          csr_d.dynamic_addr_valid = wr_i.data[31];
        end
        `I3C_REG_DEV_CHAR: begin
          csr_d.pid_hi = wr_i.data[14:0];
          csr_d.dcr    = wr_i.data[23:16];
          csr_d.bcr    = wr_i.data[31:24];
        end
        `I3C_REG_PID_LO: begin
          csr_d.pid_lo = wr_i.data;
        end
        `I3C_REG_QUEUE_SIZE: begin
          csr_d.tx_qsize = wr_i.data[2:0];
          csr_d.rx_qsize = wr_i.data[10:8];
        end
        `I3C_REG_STATUS: begin
          csr_d.protocol_error    = wr_i.data[0];
          csr_d.pending_interrupt = wr_i.data[11:8];
        end
        `I3C_REG_T_FREE: begin
          csr_d.t_free = wr_i.data[`I3C_TIMER_W-1:0];
        end
        `I3C_REG_T_IDLE: begin
          csr_d.t_idle = wr_i.data[`I3C_TIMER_W-1:0];
        end
        `I3C_REG_T_AVAL: begin
          csr_d.t_aval = wr_i.data[`I3C_TIMER_W-1:0];
        end
        default: begin
          csr_d = csr_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_q <= CSR_RESET;
    end else begin
      csr_q <= csr_d;
    end
  end

  assign ack_o = ack_q;
  assign csr_o = csr_q;

  // Host keeps the write payload steady until it has been acknowledged
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !ack_q |=> $stable(wr_i));

  // New request only after the previous ack was seen low
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_i) |-> !ack_q);

endmodule

//--- hdl/i3c_target_cfg_top.sv
// Configuration path only; no PHY, queues or IBI logic are attached here
`timescale 1ns/1ns

module i3c_target_cfg_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Host register writes
  input  logic                     csr_req_i,
  input  i3c_cfg_pkg::csr_wr_t     csr_wr_i,
  output logic                     csr_ack_o,
  // Decoded bus commands
  input  logic                     cmd_req_i,
  input  i3c_cfg_pkg::ccc_cmd_t    cmd_i,
  output logic                     cmd_ack_o,
  output i3c_cfg_pkg::ccc_resp_t   resp_o,
  output i3c_cfg_pkg::target_cfg_t cfg_o,
  output i3c_cfg_pkg::timing_cfg_t timing_o
);
  import i3c_cfg_pkg::*;

  csr_out_t    csr;
  len_update_t len_upd;

  i3c_csr_regs i_i3c_csr_regs (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (csr_req_i),
    .wr_i   (csr_wr_i),
    .ack_o  (csr_ack_o),
    .csr_o  (csr)
  );

  i3c_target_config i_i3c_target_config (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .csr_i    (csr),
    .upd_i    (len_upd),
    .cfg_o    (cfg_o),
    .timing_o (timing_o)
  );

  // Responder sees the same configuration the top exports
  i3c_ccc_responder i_i3c_ccc_responder (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (cmd_req_i),
    .cmd_i  (cmd_i),
    .cfg_i  (cfg_o),
    .ack_o  (cmd_ack_o),
    .resp_o (resp_o),
    .upd_o  (len_upd)
  );

endmodule

//--- hdl/i3c_target_config.sv
// I2C roles are not supported; length registers take their reset value from the stored queue sizes
`timescale 1ns/1ns
`include "i3c_settings.svh"

module i3c_target_config (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  i3c_cfg_pkg::csr_out_t    csr_i,
  input  i3c_cfg_pkg::len_update_t upd_i,
  output i3c_cfg_pkg::target_cfg_t cfg_o,
  output i3c_cfg_pkg::timing_cfg_t timing_o
);

  // Mode codes
  // 00 disabled
  // 01 active controller init
  // 10 standby controller running
  // 11 standby controller hot-join
  localparam logic [1:0] MODE_ACM_INIT = 2'b01;
  localparam logic [1:0] MODE_SCM_RUN  = 2'b10;
  localparam logic [1:0] MODE_SCM_HJ   = 2'b11;

  logic        active_en;
  logic        standby_en;
  logic [15:0] status_word;
  logic [15:0] mwl_q;
  logic [15:0] mrl_q;

  // Bytes in a queue of 2^(code+1) dwords
  function automatic logic [15:0] qsize_to_len(input logic [2:0] qsize);
    return 16'd4 << ({1'b0, qsize} + 4'd1);
  endfunction

  assign active_en  = (csr_i.enable_init == MODE_ACM_INIT) |
                      (csr_i.enable_init == MODE_SCM_HJ);
  assign standby_en = csr_i.enable_init == MODE_SCM_RUN;

  // Vendor byte zero, handoff not possible, then error and pending interrupt
  assign status_word = 16'({8'h00, 2'b11, csr_i.protocol_error, csr_i.pending_interrupt});

  // Defaults follow the queue depth until a SETMWL or SETMRL lands
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mwl_q <= qsize_to_len(csr_i.tx_qsize);
      mrl_q <= qsize_to_len(csr_i.rx_qsize);
    end else begin
      if (upd_i.set_mwl) begin
        mwl_q <= upd_i.value;
      end
      if (upd_i.set_mrl) begin
        mrl_q <= upd_i.value;
      end
    end
  end

  always_comb begin
    cfg_o.phy_en = csr_i.bus_enable;
    // Bit 0 picks I3C over I2C, bit 1 picks the target role
    cfg_o.phy_mux_select[0] = active_en | standby_en;
    cfg_o.phy_mux_select[1] = standby_en;
    cfg_o.i3c_active_en     = active_en;
    cfg_o.i3c_standby_en    = standby_en;

    cfg_o.sta_addr       = csr_i.static_addr;
    cfg_o.sta_addr_valid = csr_i.static_addr_valid;
    cfg_o.dyn_addr       = csr_i.dynamic_addr;
    cfg_o.dyn_addr_valid = csr_i.dynamic_addr_valid;

    // IBIs go out under the dynamic address once one is assigned
    cfg_o.ibi_addr       = csr_i.dynamic_addr_valid ? csr_i.dynamic_addr : csr_i.static_addr;
    cfg_o.ibi_addr_valid = csr_i.dynamic_addr_valid | csr_i.static_addr_valid;

    cfg_o.pid           = {csr_i.pid_hi, 1'b0, csr_i.pid_lo};
    cfg_o.bcr           = csr_i.bcr;
    cfg_o.dcr           = csr_i.dcr;
    cfg_o.mwl           = mwl_q;
    cfg_o.mrl           = mrl_q;
    cfg_o.status_fmt1   = status_word;
    cfg_o.ibi_en        = csr_i.ibi_en;
    cfg_o.ibi_retry_num = csr_i.ibi_retry_num;
  end

  always_comb begin
    timing_o.t_bus_free      = csr_i.t_free;
    timing_o.t_bus_idle      = csr_i.t_idle;
    timing_o.t_bus_available = csr_i.t_aval;
  end

  // Reserved addresses never become the target's dynamic address
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_i.dynamic_addr_valid |->
      !(csr_i.dynamic_addr inside {`I3C_BCAST_ADDR, `I3C_HOT_JOIN_ADDR}));

  // Same for a static address that the target answers to
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_i.static_addr_valid |-> csr_i.static_addr != `I3C_BCAST_ADDR);

endmodule

//--- include/i3c_settings.svh
// Register indices are 4-bit word numbers; queue size codes must stay in 0..7
`ifndef I3C_SETTINGS_SVH
`define I3C_SETTINGS_SVH

// Host register word indices
`define I3C_REG_CONTROL    4'h0
`define I3C_REG_DEV_ADDR   4'h1
`define I3C_REG_DEV_CHAR   4'h2
`define I3C_REG_PID_LO     4'h3
`define I3C_REG_QUEUE_SIZE 4'h4
`define I3C_REG_STATUS     4'h5
`define I3C_REG_T_FREE     4'h6
`define I3C_REG_T_IDLE     4'h7
`define I3C_REG_T_AVAL     4'h8

// Enough for about 1 ms of bus timing at 1 GHz
`define I3C_TIMER_W 20

`define I3C_RST_TX_QSIZE 3'd4
`define I3C_RST_RX_QSIZE 3'd3

`define I3C_HOT_JOIN_ADDR 7'h02
`define I3C_BCAST_ADDR    7'h7E

`endif

//--- test/tb_i3c_target_cfg.sv
// Directed tests; expected values come from a model of the written fields, queue sizes stay at reset
`timescale 1ns/1ns
`include "i3c_settings.svh"

module tb_i3c_target_cfg;
  import i3c_cfg_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int CYCLE_LIMIT = NUM_TESTS * 200;
  localparam int TIMER_W     = `I3C_TIMER_W;

  logic        clk;
  logic        rst_n;
  logic        csr_req;
  csr_wr_t     csr_wr;
  logic        csr_ack;
  logic        cmd_req;
  ccc_cmd_t    cmd;
  logic        cmd_ack;
  ccc_resp_t   resp;
  target_cfg_t cfg;
  timing_cfg_t timing;

  // Model of what the DUT should hold
  csr_out_t    shadow;
  logic [15:0] exp_mwl;
  logic [15:0] exp_mrl;
  logic [31:0] lcg_state;
  string       test_name;
  int          errors;
  int          checks;
  int          errors_at_start;
  int          tests_done;
  int          cycles;

  i3c_target_cfg_top i_i3c_target_cfg_top (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .csr_req_i (csr_req),
    .csr_wr_i  (csr_wr),
    .csr_ack_o (csr_ack),
    .cmd_req_i (cmd_req),
    .cmd_i     (cmd),
    .cmd_ack_o (cmd_ack),
    .resp_o    (resp),
    .cfg_o     (cfg),
    .timing_o  (timing)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Checks failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Broadcast and hot-join codes are never assigned to a target
  function automatic logic [6:0] rand_addr();
    logic [6:0] a;
    a = 7'(lcg_next() >> 9);
    while (a == `I3C_BCAST_ADDR || a == `I3C_HOT_JOIN_ADDR) begin
      a = 7'(lcg_next() >> 9);
    end
    return a;
  endfunction

  function automatic logic [15:0] len_for_qsize(input logic [2:0] q);
    return 16'(4 * (2 ** (int'(q) + 1)));
  endfunction

  function automatic void reset_model();
    shadow          = '0;
    shadow.tx_qsize = `I3C_RST_TX_QSIZE;
    shadow.rx_qsize = `I3C_RST_RX_QSIZE;
    exp_mwl         = len_for_qsize(shadow.tx_qsize);
    exp_mrl         = len_for_qsize(shadow.rx_qsize);
  endfunction

  // Register word layout as the host writes it
  function automatic logic [31:0] pack_word(input logic [3:0] idx);
    logic [31:0] w;
    w = '0;
    case (idx)
      `I3C_REG_CONTROL: w = {20'h0, shadow.ibi_retry_num, shadow.ibi_en, 2'b00,
                             shadow.enable_init, 3'b000, shadow.bus_enable};
      `I3C_REG_DEV_ADDR: w = {shadow.dynamic_addr_valid, 8'h00, shadow.dynamic_addr,
                              shadow.static_addr_valid, 8'h00, shadow.static_addr};
      `I3C_REG_DEV_CHAR: w = {shadow.bcr, shadow.dcr, 1'b0, shadow.pid_hi};
      `I3C_REG_PID_LO: w = shadow.pid_lo;
      `I3C_REG_STATUS: w = {20'h0, shadow.pending_interrupt, 7'h00, shadow.protocol_error};
      `I3C_REG_T_FREE: w = {{(32 - TIMER_W){1'b0}}, shadow.t_free};
      `I3C_REG_T_IDLE: w = {{(32 - TIMER_W){1'b0}}, shadow.t_idle};
      `I3C_REG_T_AVAL: w = {{(32 - TIMER_W){1'b0}}, shadow.t_aval};
      default: w = '0;
    endcase
    return w;
  endfunction

  function automatic logic [47:0] model_pid();
    return {shadow.pid_hi, 1'b0, shadow.pid_lo};
  endfunction

  // Format 1 word of vendor byte zero, handoff code, error bit and pending interrupt
  function automatic logic [15:0] status_word();
    return {1'b0, 8'h00, 2'b11, shadow.protocol_error, shadow.pending_interrupt};
  endfunction

  function automatic target_cfg_t expect_cfg();
    target_cfg_t c;
    logic        act;
    logic        stb;
    act              = shadow.enable_init == 2'b01 || shadow.enable_init == 2'b11;
    stb              = shadow.enable_init == 2'b10;
    c.phy_en         = shadow.bus_enable;
    c.phy_mux_select = {stb, act | stb};
    c.i3c_active_en  = act;
    c.i3c_standby_en = stb;
    c.sta_addr       = shadow.static_addr;
    c.sta_addr_valid = shadow.static_addr_valid;
    c.dyn_addr       = shadow.dynamic_addr;
    c.dyn_addr_valid = shadow.dynamic_addr_valid;
    c.ibi_addr       = shadow.dynamic_addr_valid ? shadow.dynamic_addr : shadow.static_addr;
    c.ibi_addr_valid = shadow.dynamic_addr_valid | shadow.static_addr_valid;
    c.pid            = model_pid();
    c.bcr            = shadow.bcr;
    c.dcr            = shadow.dcr;
    c.mwl            = exp_mwl;
    c.mrl            = exp_mrl;
    c.status_fmt1    = status_word();
    c.ibi_en         = shadow.ibi_en;
    c.ibi_retry_num  = shadow.ibi_retry_num;
    return c;
  endfunction

  function automatic timing_cfg_t expect_timing();
    return '{t_bus_free: shadow.t_free, t_bus_idle: shadow.t_idle,
             t_bus_available: shadow.t_aval};
  endfunction

  function automatic ccc_resp_t expect_resp(input ccc_kind_e op, input logic [6:0] addr);
    ccc_resp_t  r;
    logic       own_v;
    logic [6:0] own;
    logic       direct;
    logic       bcast;
    r      = '0;
    own_v  = shadow.dynamic_addr_valid | shadow.static_addr_valid;
    own    = shadow.dynamic_addr_valid ? shadow.dynamic_addr : shadow.static_addr;
    direct = own_v && addr == own;
    bcast  = addr == `I3C_BCAST_ADDR;
    case (op)
      CMD_ENTDAA: begin
        if (bcast && !shadow.dynamic_addr_valid) begin
          r = '{hit: 1'b1, data: {model_pid(), shadow.bcr, shadow.dcr}, nbytes: 4'd8};
        end
      end
      CMD_GETPID: if (direct || bcast) r = '{hit: 1'b1, data: {16'h0, model_pid()}, nbytes: 4'd6};
      CMD_GETMWL: if (direct || bcast) r = '{hit: 1'b1, data: {48'h0, exp_mwl}, nbytes: 4'd2};
      CMD_GETMRL: if (direct || bcast) r = '{hit: 1'b1, data: {48'h0, exp_mrl}, nbytes: 4'd2};
      CMD_GETSTATUS: begin
        if (direct || bcast) r = '{hit: 1'b1, data: {48'h0, status_word()}, nbytes: 4'd2};
      end
      CMD_PRIVATE: r.hit = direct;
      default: r.hit = direct | bcast;
    endcase
    return r;
  endfunction

  task automatic check_cfg(input string what, input target_cfg_t exp, input target_cfg_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_timing(input string what, input timing_cfg_t exp, input timing_cfg_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input ccc_resp_t exp, input ccc_resp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_outputs(input string what);
    check_cfg(what, expect_cfg(), cfg);
    check_timing(what, expect_timing(), timing);
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_done++;
    $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
  endtask

  // Four-phase master that samples ack on the falling edge
  task automatic csr_write(input logic [3:0] idx, input logic [31:0] data);
    @(posedge clk);
    csr_req <= 1'b1;
    csr_wr  <= '{addr: idx, data: data};
    @(negedge clk);
    while (csr_ack !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    csr_req <= 1'b0;
    @(negedge clk);
    while (csr_ack !== 1'b0) begin
      @(negedge clk);
    end
  endtask

  task automatic write_reg(input logic [3:0] idx);
    csr_write(idx, pack_word(idx));
  endtask

  task automatic send_cmd(input ccc_kind_e op, input logic [6:0] addr, input logic [15:0] data,
                          output ccc_resp_t r);
    @(posedge clk);
    cmd_req <= 1'b1;
    cmd     <= '{kind: op, addr: addr, data: data};
    @(negedge clk);
    while (cmd_ack !== 1'b1) begin
      @(negedge clk);
    end
    r = resp;
    @(posedge clk);
    cmd_req <= 1'b0;
    @(negedge clk);
    while (cmd_ack !== 1'b0) begin
      @(negedge clk);
    end
  endtask

  task automatic run_cmd(input string what, input ccc_kind_e op, input logic [6:0] addr,
                         input logic [15:0] data);
    ccc_resp_t exp;
    ccc_resp_t got;
    exp = expect_resp(op, addr);
    send_cmd(op, addr, data, got);
    check_resp(what, exp, got);
    // An accepted SET changes what later GET commands report
    if (exp.hit && op == CMD_SETMWL) begin
      exp_mwl = data;
    end
    if (exp.hit && op == CMD_SETMRL) begin
      exp_mrl = data;
    end
  endtask

  task automatic test_reset_values();
    begin_test("reset_values");
    check_outputs("after reset");
    checks++;
    if ({csr_ack, cmd_ack} !== 2'b00) begin
      errors++;
      $display("FAILED %s acks after reset: expected %b, actual %b", test_name, 2'b00,
               {csr_ack, cmd_ack});
    end
    end_test();
  endtask

  task automatic test_mode_timing();
    logic [31:0] rnd;
    begin_test("mode_timing");
    for (int m = 0; m < 4; m++) begin
      rnd                  = lcg_next();
      shadow.bus_enable    = rnd[0];
      shadow.ibi_en        = rnd[1];
      shadow.ibi_retry_num = rnd[4:2];
      shadow.enable_init   = 2'(m);
      shadow.t_free        = TIMER_W'(lcg_next());
      shadow.t_idle        = TIMER_W'(lcg_next());
      shadow.t_aval        = TIMER_W'(lcg_next());
      write_reg(`I3C_REG_CONTROL);
      write_reg(`I3C_REG_T_FREE);
      write_reg(`I3C_REG_T_IDLE);
      write_reg(`I3C_REG_T_AVAL);
      check_outputs($sformatf("mode %0d", m));
    end
    end_test();
  endtask

  task automatic test_address_select();
    begin_test("address_select");
    shadow.static_addr  = rand_addr();
    shadow.dynamic_addr = rand_addr();
    while (shadow.dynamic_addr == shadow.static_addr) begin
      shadow.dynamic_addr = rand_addr();
    end
    for (int v = 0; v < 4; v++) begin
      shadow.static_addr_valid  = v[0];
      shadow.dynamic_addr_valid = v[1];
      write_reg(`I3C_REG_DEV_ADDR);
      check_outputs($sformatf("valid bits %0d", v));
      run_cmd($sformatf("private to static, valid bits %0d", v), CMD_PRIVATE,
              shadow.static_addr, 16'(lcg_next()));
      run_cmd($sformatf("private to dynamic, valid bits %0d", v), CMD_PRIVATE,
              shadow.dynamic_addr, 16'(lcg_next()));
    end
    end_test();
  endtask

  task automatic test_entdaa_getpid();
    begin_test("entdaa_getpid");
    shadow.pid_hi             = 15'(lcg_next());
    shadow.pid_lo             = lcg_next();
    shadow.bcr                = 8'(lcg_next());
    shadow.dcr                = 8'(lcg_next());
    shadow.static_addr        = rand_addr();
    shadow.static_addr_valid  = 1'b1;
    shadow.dynamic_addr_valid = 1'b0;
    write_reg(`I3C_REG_DEV_CHAR);
    write_reg(`I3C_REG_PID_LO);
    write_reg(`I3C_REG_DEV_ADDR);
    check_outputs("identity");
    run_cmd("entdaa unassigned", CMD_ENTDAA, `I3C_BCAST_ADDR, 16'h0);
    run_cmd("getpid static", CMD_GETPID, shadow.static_addr, 16'h0);
    // Once assigned, the target drops out of ENTDAA
    shadow.dynamic_addr = rand_addr();
    while (shadow.dynamic_addr == shadow.static_addr) begin
      shadow.dynamic_addr = rand_addr();
    end
    shadow.dynamic_addr_valid = 1'b1;
    write_reg(`I3C_REG_DEV_ADDR);
    run_cmd("entdaa assigned", CMD_ENTDAA, `I3C_BCAST_ADDR, 16'h0);
    run_cmd("getpid dynamic", CMD_GETPID, shadow.dynamic_addr, 16'h0);
    end_test();
  endtask

  task automatic test_length_update();
    begin_test("length_update");
    run_cmd("setmwl broadcast", CMD_SETMWL, `I3C_BCAST_ADDR, 16'(lcg_next()));
    run_cmd("setmwl other target", CMD_SETMWL, shadow.dynamic_addr ^ 7'h01, 16'(lcg_next()));
    run_cmd("getmwl broadcast", CMD_GETMWL, `I3C_BCAST_ADDR, 16'h0);
    run_cmd("setmrl direct", CMD_SETMRL, shadow.dynamic_addr, 16'(lcg_next()));
    run_cmd("getmrl direct", CMD_GETMRL, shadow.dynamic_addr, 16'h0);
    check_outputs("after set");
    apply_reset();
    reset_model();
    check_outputs("after reset");
    run_cmd("getmwl after reset", CMD_GETMWL, `I3C_BCAST_ADDR, 16'h0);
    run_cmd("getmrl after reset", CMD_GETMRL, `I3C_BCAST_ADDR, 16'h0);
    end_test();
  endtask

  task automatic test_getstatus();
    logic [31:0] rnd;
    logic [6:0]  addr;
    begin_test("getstatus");
    shadow.static_addr       = rand_addr();
    shadow.static_addr_valid = 1'b1;
    write_reg(`I3C_REG_DEV_ADDR);
    for (int i = 0; i < 4; i++) begin
      rnd                      = lcg_next();
      shadow.protocol_error    = rnd[0];
      shadow.pending_interrupt = rnd[11:8];
      write_reg(`I3C_REG_STATUS);
      check_outputs($sformatf("status %0d", i));
      addr = i[0] ? shadow.static_addr : `I3C_BCAST_ADDR;
      run_cmd($sformatf("getstatus %0d", i), CMD_GETSTATUS, addr, 16'h0);
    end
    end_test();
  endtask

  initial begin
    rst_n      = 1'b0;
    csr_req    = 1'b0;
    csr_wr     = '0;
    cmd_req    = 1'b0;
    cmd        = '0;
    lcg_state  = 32'hddec_9f44;
    errors     = 0;
    checks     = 0;
    tests_done = 0;
    test_name  = "";
    reset_model();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    test_reset_values();
    test_mode_timing();
    test_address_select();
    test_entdaa_getpid();
    test_length_update();
    test_getstatus();

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
